// ==== sdram_pkg.sv ====
//--------------------------------------
// Shared SDRAM controller definitions
// Chip geometry and mode word
// Command, state and opcode enums
// Host, pin and access structs
//--------------------------------------
`default_nettype none

package sdram_pkg;

    // 4 banks of 2048 rows by 256 columns, 32-bit words
    localparam int col_width  = 8;
    localparam int row_width  = 11;
    localparam int bank_width = 2;
    localparam int dq_width   = 32;
    localparam int dqm_width  = dq_width / 8;
    // Byte address with lane bits below the column
    localparam int addr_width = $clog2(dqm_width) + col_width + row_width + bank_width;

    // Write burst on, CAS latency 2, sequential, burst length 1
    localparam logic [row_width-1:0] mode_word = {1'b0, 1'b0, 2'b00, 3'b010, 1'b0, 3'b000};

    // Encoded as {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        DIS  = 4'b1111,
        SMR  = 4'b0000,
        REF  = 4'b0001,
        PRE  = 4'b0010,
        ACT  = 4'b0011,
        WR   = 4'b0100,
        RD   = 4'b0101,
        BEND = 4'b0110,
        NOP  = 4'b0111
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        INIT_PRE,
        INIT_REF1,
        INIT_REF2,
        INIT_SMR,
        IDLE,
        SETUP,
        ACCESS,
        WAIT,
        FETCH,
        RESP
    } ctrl_state_e;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_REFRESH
    } req_op_e;

    typedef struct packed {
        req_op_e               op;
        logic [addr_width-1:0] addr;
        logic [7:0]            wdata;
    } host_req_t;

    // Low byte from the address, high byte from its half-word neighbour
    typedef struct packed {
        logic [15:0] rd_data;
    } host_rsp_t;

    typedef struct packed {
        sdram_cmd_e            cmd;
        logic [bank_width-1:0] ba;
        logic [row_width-1:0]  a;
        logic [dqm_width-1:0]  dqm;
    } sdram_pins_t;

    // Registered request as seen by the controller and the DQ path
    typedef struct packed {
        logic [bank_width-1:0] bank;
        logic [row_width-1:0]  row;
        logic [col_width-1:0]  col;
        logic [1:0]            lane;
        logic [dqm_width-1:0]  dqm;
        logic [7:0]            wdata;
    } access_t;

endpackage

`default_nettype wire

// ==== sdram_ctrl.sv ====
//--------------------------------------
// SDRAM control FSM
// Init sequence, request handshake,
// command issue and response hand-off
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl #(
    parameter int INIT_GAP = 8
) (
    input  wire                       CLK,
    input  wire                       RESET_n,
    input  wire                       req_valid,
    output logic                      req_ready,
    input  wire sdram_pkg::req_op_e   req_op,
    output logic                      accept,
    input  wire sdram_pkg::access_t   acc,
    output sdram_pkg::sdram_pins_t    pins,
    output logic                      dq_oe,
    output logic                      fetch,
    output logic                      rsp_valid,
    input  wire                       rsp_ready
);
    import sdram_pkg::*;

    // Counter holds the init gap and the two-cycle dwells
    localparam int CNT_W = (INIT_GAP > 2) ? $clog2(INIT_GAP) : 1;
    localparam logic [CNT_W-1:0] GAP_LAST = CNT_W'(INIT_GAP - 1);
    localparam logic [CNT_W-1:0] TWO_CYC  = CNT_W'(1);

    ctrl_state_e      state;
    ctrl_state_e      state_nxt;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_nxt;
    req_op_e          op_q;
    req_op_e          op_nxt;
    sdram_pins_t      pins_nxt;
    logic             first;
    logic             last;

    // First cycle of an init slot issues its command
    assign first = (cnt == GAP_LAST);
    assign last  = (cnt == '0);

    always_comb
    begin
        state_nxt    = state;
        cnt_nxt      = last ? cnt : cnt - 1'b1;
        op_nxt       = op_q;
        pins_nxt.cmd = NOP;
        pins_nxt.ba  = '0;
        pins_nxt.a   = '0;
        pins_nxt.dqm = '0;
        case (state)
            INIT_PRE:
            begin
                // Precharge all banks via A10
                if (first)
                begin
                    pins_nxt.cmd   = PRE;
                    pins_nxt.a[10] = 1'b1;
                end
                if (last)
                begin
                    state_nxt = INIT_REF1;
                    cnt_nxt   = GAP_LAST;
                end
            end
            INIT_REF1, INIT_REF2:
            begin
                if (first)
                    pins_nxt.cmd = REF;
                if (last)
                begin
                    state_nxt = (state == INIT_REF1) ? INIT_REF2 : INIT_SMR;
                    cnt_nxt   = GAP_LAST;
                end
            end
            INIT_SMR:
            begin
                if (first)
                begin
                    pins_nxt.cmd = SMR;
                    pins_nxt.a   = mode_word;
                end
                if (last)
                    state_nxt = IDLE;
            end
            IDLE:
            begin
                // Op held for the whole access
                if (accept)
                begin
                    state_nxt = SETUP;
                    op_nxt    = req_op;
                end
            end
            SETUP:
            begin
                // Address map output is valid from here on
                if (op_q == OP_REFRESH)
                    pins_nxt.cmd = REF;
                else
                begin
                    pins_nxt.cmd = ACT;
                    pins_nxt.ba  = acc.bank;
                    pins_nxt.a   = acc.row;
                end
                state_nxt = ACCESS;
                cnt_nxt   = TWO_CYC;
            end
            ACCESS:
            begin
                // Column command with auto-precharge on A10
                if (last)
                begin
                    if (op_q != OP_REFRESH)
                    begin
                        pins_nxt.cmd                = (op_q == OP_WRITE) ? WR : RD;
                        pins_nxt.ba                 = acc.bank;
                        pins_nxt.a[10]              = 1'b1;
                        pins_nxt.a[col_width-1:0]   = acc.col;
                        pins_nxt.dqm                = acc.dqm;
                    end
                    state_nxt = WAIT;
                    cnt_nxt   = TWO_CYC;
                end
            end
            WAIT:
            begin
                // CAS latency
                if (last)
                begin
                    state_nxt = FETCH;
                    cnt_nxt   = TWO_CYC;
                end
            end
            FETCH:
            begin
                if (last)
                    state_nxt = RESP;
            end
            RESP:
            begin
                // Writes and refresh have no response to hand off
                if (op_q != OP_READ || rsp_ready)
                    state_nxt = IDLE;
            end
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
        begin
            state <= INIT_PRE;
            cnt   <= GAP_LAST;
            op_q  <= OP_READ;
            pins  <= '{cmd: NOP, default: '0};
        end
        else
        begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
            op_q  <= op_nxt;
            pins  <= pins_nxt;
        end
    end

    assign req_ready = (state == IDLE);
    assign accept    = req_valid && req_ready;
    // Write data on DQ around the WR command
    assign dq_oe     = (op_q == OP_WRITE) && (state inside {SETUP, ACCESS, WAIT});
    // Read data sampled at the end of the first FETCH cycle
    assign fetch     = (op_q == OP_READ) && (state == FETCH) && (cnt == TWO_CYC);
    assign rsp_valid = (op_q == OP_READ) && (state == RESP);

endmodule

`default_nettype wire

// ==== sdram_addr_map.sv ====
//--------------------------------------
// Request register and address split
// into bank, row, column, lane and mask
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdram_addr_map (
    input  wire                       CLK,
    input  wire                       RESET_n,
    input  wire                       accept,
    input  wire sdram_pkg::host_req_t req,
    output sdram_pkg::access_t        acc
);
    import sdram_pkg::*;

    // Byte address is {bank, row, col, lane}
    localparam int COL_LSB  = 2;
    localparam int ROW_LSB  = COL_LSB + col_width;
    localparam int BANK_LSB = ROW_LSB + row_width;

    logic [dqm_width-1:0] wr_mask;

    // Only the addressed lane is written
    assign wr_mask = ~(dqm_width'(1) << req.addr[1:0]);

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
            acc <= '0;
        else if (accept)
        begin
            acc.bank  <= req.addr[BANK_LSB +: bank_width];
            acc.row   <= req.addr[ROW_LSB +: row_width];
            acc.col   <= req.addr[COL_LSB +: col_width];
            acc.lane  <= req.addr[1:0];
            // Reads and refresh leave every lane enabled
            acc.dqm   <= (req.op == OP_WRITE) ? wr_mask : '0;
            acc.wdata <= req.wdata;
        end
    end

endmodule

`default_nettype wire

// ==== sdram_dq_path.sv ====
//--------------------------------------
// DQ datapath
// Write byte replication and tristate,
// read half-word and byte ordering
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdram_dq_path (
    input  wire                      CLK,
    input  wire                      RESET_n,
    input  wire sdram_pkg::access_t  acc,
    input  wire                      dq_oe,
    input  wire                      fetch,
    output sdram_pkg::host_rsp_t     rsp,
    inout  wire [sdram_pkg::dq_width-1:0] dq
);
    import sdram_pkg::*;

    localparam int HALF = dq_width / 2;

    logic [dq_width-1:0] dq_out;
    logic                dq_en;
    logic [HALF-1:0]     half;

    // Output enable lags dq_oe by one cycle
    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
            dq_en <= 1'b0;
        else
            dq_en <= dq_oe;
    end

    // Same byte on all lanes, DQM picks the one written
    always_ff @(posedge CLK)
    begin
        dq_out <= {dqm_width{acc.wdata}};
    end

    assign dq = dq_en ? dq_out : 'z;

    // Half-word holding the addressed byte
    assign half = acc.lane[1] ? dq[dq_width-1:HALF] : dq[HALF-1:0];

    always_ff @(posedge CLK)
    begin
        if (fetch)
        begin
            // Odd byte swaps so the addressed byte lands low
            if (acc.lane[0])
                rsp.rd_data <= {half[7:0], half[15:8]};
            else
                rsp.rd_data <= half;
        end
    end

endmodule

`default_nettype wire

// ==== sdram_top.sv ====
//--------------------------------------
// SDRAM controller top level
// Control, address map and DQ path
// SDRAM pin split and clock output
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdram_top #(
    parameter int INIT_GAP = 8
) (
    input  wire                                  CLK,
    input  wire                                  RESET_n,
    input  wire                                  req_valid,
    output logic                                 req_ready,
    input  wire sdram_pkg::host_req_t            req,
    output logic                                 rsp_valid,
    input  wire                                  rsp_ready,
    output sdram_pkg::host_rsp_t                 rsp,
    output logic                                 sdram_clk,
    output logic                                 sdram_cke,
    output logic                                 sdram_cs_n,
    output logic                                 sdram_ras_n,
    output logic                                 sdram_cas_n,
    output logic                                 sdram_we_n,
    output logic [sdram_pkg::row_width-1:0]      sdram_a,
    output logic [sdram_pkg::bank_width-1:0]     sdram_ba,
    output logic [sdram_pkg::dqm_width-1:0]      sdram_dqm,
    inout  wire  [sdram_pkg::dq_width-1:0]       dq
);
    import sdram_pkg::*;

    logic        accept;
    logic        dq_oe;
    logic        fetch;
    access_t     acc;
    sdram_pins_t pins;

    sdram_ctrl #(
        .INIT_GAP (INIT_GAP)
    ) i_ctrl (
        .CLK       (CLK),
        .RESET_n   (RESET_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_op    (req.op),
        .accept    (accept),
        .acc       (acc),
        .pins      (pins),
        .dq_oe     (dq_oe),
        .fetch     (fetch),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    sdram_addr_map i_addr_map (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .accept  (accept),
        .req     (req),
        .acc     (acc)
    );

    sdram_dq_path i_dq_path (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .acc     (acc),
        .dq_oe   (dq_oe),
        .fetch   (fetch),
        .rsp     (rsp),
        .dq      (dq)
    );

    // Chip samples on the falling edge of CLK
    assign sdram_clk = ~CLK;
    // No power-down
    assign sdram_cke = 1'b1;
    assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = pins.cmd;
    assign sdram_a   = pins.a;
    assign sdram_ba  = pins.ba;
    assign sdram_dqm = pins.dqm;

endmodule

`default_nettype wire

// ==== sdram_model.sv ====
//--------------------------------------
// Behavioural SDR SDRAM
// CAS latency 2, byte masks on writes,
// command log for init checks
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire                                  clk,
    input  wire                                  cs_n,
    input  wire                                  ras_n,
    input  wire                                  cas_n,
    input  wire                                  we_n,
    input  wire  [sdram_pkg::row_width-1:0]      a,
    input  wire  [sdram_pkg::bank_width-1:0]     ba,
    input  wire  [sdram_pkg::dqm_width-1:0]      dqm,
    inout  wire  [sdram_pkg::dq_width-1:0]       dq
);
    import sdram_pkg::*;

    sdram_cmd_e           cmd;
    sdram_cmd_e           log_cmd[$];
    logic [row_width-1:0] log_a[$];
    logic [31:0]          mem [int];
    logic [row_width-1:0] open_row [0:3];
    logic [31:0]          rd_word;
    logic [31:0]          wr_word;
    logic [1:0]           rd_cnt = '0;
    logic                 rd_oe  = 1'b0;
    int                   key;

    assign cmd = sdram_cmd_e'({cs_n, ras_n, cas_n, we_n});
    assign dq  = rd_oe ? rd_word : 'z;

    // Unwritten bytes follow a pattern of the full byte address
    function automatic logic [7:0] fill_byte(input logic [22:0] b);
        return b[7:0] ^ b[15:8] ^ {1'b0, b[22:16]} ^ 8'h5a;
    endfunction

    function automatic logic [31:0] word_at(input int k);
        logic [31:0] w;
        if (mem.exists(k))
            return mem[k];
        for (int l = 0; l < 4; l++)
            w[8*l +: 8] = fill_byte({k[20:0], 2'(l)});
        return w;
    endfunction

    always @(posedge clk)
    begin
        // Data out two clocks after RD, held for one clock
        rd_oe <= (rd_cnt == 2'd1);
        if (rd_cnt != 0)
            rd_cnt <= rd_cnt - 1'b1;
        if (!(cmd inside {NOP, DIS}))
        begin
            log_cmd.push_back(cmd);
            log_a.push_back(a);
        end
        key = int'({ba, open_row[ba], a[col_width-1:0]});
        case (cmd)
            ACT:
                open_row[ba] <= a;
            RD:
            begin
                rd_word <= word_at(key);
                rd_cnt  <= 2'd2;
            end
            WR:
            begin
                wr_word = word_at(key);
                // DQM low enables the lane
                for (int l = 0; l < 4; l++)
                    if (!dqm[l])
                        wr_word[8*l +: 8] = dq[8*l +: 8];
                mem[key] = wr_word;
            end
            default:
                ;
        endcase
    end

endmodule

`default_nettype wire

// ==== sdram_properties.sv ====
//--------------------------------------
// Controller assertions
// DQ enable, ready and response rules
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdram_properties (
    input wire                      CLK,
    input wire                      RESET_n,
    input wire sdram_pkg::req_op_e  req_op,
    input wire                      dq_oe,
    input wire                      accept,
    input wire                      req_ready,
    input wire                      rsp_valid,
    input wire                      rsp_ready
);
    import sdram_pkg::*;

    // Count of failed assertions
    int n_fail = 0;

    // No bus drive while a read is in flight
    a_no_oe_on_read: assert property (@(posedge CLK) disable iff (!RESET_n)
        accept && req_op == OP_READ |=> !dq_oe [*8])
        else
        begin
            n_fail++;
            $error("dq_oe high during a read");
        end

    // Shortest access keeps ready low for 8 cycles
    a_ready_low: assert property (@(posedge CLK) disable iff (!RESET_n)
        accept |=> !req_ready [*8])
        else
        begin
            n_fail++;
            $error("req_ready high during an access");
        end

    a_rsp_hold: assert property (@(posedge CLK) disable iff (!RESET_n)
        rsp_valid && !rsp_ready |=> rsp_valid)
        else
        begin
            n_fail++;
            $error("rsp_valid dropped before rsp_ready");
        end

endmodule

bind sdram_ctrl sdram_properties i_props (
    .CLK       (CLK),
    .RESET_n   (RESET_n),
    .req_op    (req_op),
    .dq_oe     (dq_oe),
    .accept    (accept),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
);

`default_nettype wire

// ==== tb_sdram.sv ====
//--------------------------------------
// SDRAM controller testbench
// Case file and random write/read pairs,
// scoreboard, init log and timeout
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_sdram;
    import sdram_pkg::*;

    localparam int INIT_GAP  = 8;
    localparam int N_RAND    = 16;
    localparam int MAX_CASES = 32;
    localparam int PERIOD    = 40;

    logic                  CLK;
    logic                  RESET_n;
    logic                  req_valid;
    logic                  rsp_ready;
    host_req_t             req;
    host_rsp_t             rsp;
    wire                   req_ready;
    wire                   rsp_valid;
    wire                   sdram_clk;
    wire                   sdram_cke;
    wire                   cs_n;
    wire                   ras_n;
    wire                   cas_n;
    wire                   we_n;
    wire [row_width-1:0]   sdram_a;
    wire [bank_width-1:0]  sdram_ba;
    wire [dqm_width-1:0]   sdram_dqm;
    wire [dq_width-1:0]    dq;

    logic [31:0] cases_mem [0:4*MAX_CASES-1];
    logic [7:0]  sb [int];
    logic [31:0] rng;
    int          n_cases;
    int          cycles;
    int          cycle_limit;
    int          mismatches;
    int          failures;
    int          n_assert;

    sdram_top #(
        .INIT_GAP (INIT_GAP)
    ) i_dut (
        .CLK (CLK), .RESET_n (RESET_n),
        .req_valid (req_valid), .req_ready (req_ready), .req (req),
        .rsp_valid (rsp_valid), .rsp_ready (rsp_ready), .rsp (rsp),
        .sdram_clk (sdram_clk), .sdram_cke (sdram_cke),
        .sdram_cs_n (cs_n), .sdram_ras_n (ras_n),
        .sdram_cas_n (cas_n), .sdram_we_n (we_n),
        .sdram_a (sdram_a), .sdram_ba (sdram_ba),
        .sdram_dqm (sdram_dqm), .dq (dq)
    );

    sdram_model i_model (
        .clk (sdram_clk), .cs_n (cs_n), .ras_n (ras_n), .cas_n (cas_n),
        .we_n (we_n), .a (sdram_a), .ba (sdram_ba), .dqm (sdram_dqm), .dq (dq)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD/2) CLK = ~CLK;
    end

    // Watchdog
    initial
    begin
        cycles = 0;
        do
        begin
            @(posedge CLK);
            cycles++;
        end
        while (cycle_limit == 0 || cycles <= cycle_limit);
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Memory contents before any write
    function automatic logic [7:0] init_byte(input logic [22:0] b);
        return b[7:0] ^ b[15:8] ^ {1'b0, b[22:16]} ^ 8'h5a;
    endfunction

    function automatic logic [7:0] sb_byte(input logic [22:0] b);
        return sb.exists(int'(b)) ? sb[int'(b)] : init_byte(b);
    endfunction

    task automatic check_rsp(input string name, input host_rsp_t got, input host_rsp_t exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_cmd(input string name, input sdram_cmd_e got, input sdram_cmd_e exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pin_a(input string name, input logic [row_width-1:0] got,
                               input logic [row_width-1:0] exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Returns on the edge where the request is taken
    task automatic send_request(input req_op_e op, input logic [22:0] addr, input logic [7:0] wd);
        @(posedge CLK);
        req_valid <= 1'b1;
        req       <= '{op: op, addr: addr, wdata: wd};
        do
            @(negedge CLK);
        while (!req_ready);
        // Clock enable is tied high
        check_bit("sdram_cke", sdram_cke, 1'b1);
        @(posedge CLK);
        req_valid <= 1'b0;
    endtask

    task automatic wait_response(output host_rsp_t got);
        host_rsp_t first_rsp;
        bit        seen;
        bit        done;
        int        hold;
        seen = 0;
        done = 0;
        hold = int'(next_rand() % 4);
        while (!done)
        begin
            @(negedge CLK);
            if (rsp_valid)
            begin
                if (!seen)
                    first_rsp = rsp;
                else
                    check_rsp("rsp held", rsp, first_rsp);
                seen = 1;
                if (req_ready)
                begin
                    failures++;
                    $display("Request ready while a response is pending");
                end
                if (rsp_ready)
                begin
                    got  = rsp;
                    done = 1;
                end
                else if (hold > 0)
                    hold--;
            end
            @(posedge CLK);
            rsp_ready <= !done && seen && hold == 0;
        end
    endtask

    task automatic write_byte(input logic [22:0] addr, input logic [7:0] wd);
        send_request(OP_WRITE, addr, wd);
        sb[int'(addr)] = wd;
    endtask

    task automatic read_half(input logic [22:0] addr, input host_rsp_t exp);
        host_rsp_t got;
        send_request(OP_READ, addr, 8'h00);
        wait_response(got);
        check_rsp("rsp", got, exp);
    endtask

    task automatic refresh_once();
        int n_log;
        int n;
        n_log = i_model.log_cmd.size();
        n     = 0;
        send_request(OP_REFRESH, 23'h0, 8'h00);
        forever
        begin
            @(negedge CLK);
            if (req_ready)
                break;
            if (rsp_valid)
            begin
                failures++;
                $display("Refresh produced a response");
            end
            @(posedge CLK);
            n++;
        end
        if (n != 8)
        begin
            failures++;
            $display("req_ready came back %0d cycles after refresh, not 8", n);
        end
        if (i_model.log_cmd.size() == n_log)
        begin
            failures++;
            $display("No SDRAM command seen for the refresh request");
        end
        else
            check_cmd("refresh cmd", i_model.log_cmd[n_log], REF);
    endtask

    task automatic check_init_log();
        int base;
        // Commands logged before reset release do not count
        base = i_model.log_cmd.size();
        do
            @(negedge CLK);
        while (!req_ready);
        if (i_model.log_cmd.size() - base != 4)
        begin
            failures++;
            $display("Init logged %0d commands instead of 4", i_model.log_cmd.size() - base);
        end
        else
        begin
            check_cmd("init cmd 0", i_model.log_cmd[base], PRE);
            check_pin_a("init a10", {10'h0, i_model.log_a[base][10]}, 11'h1);
            check_cmd("init cmd 1", i_model.log_cmd[base+1], REF);
            check_cmd("init cmd 2", i_model.log_cmd[base+2], REF);
            check_cmd("init cmd 3", i_model.log_cmd[base+3], SMR);
            // CL 2 in bits 6:4, sequential, length 1
            check_pin_a("mode word", i_model.log_a[base+3], 11'h020);
        end
    endtask

    initial
    begin
        logic [22:0] addr;
        logic [7:0]  wd;
        RESET_n     = 1'b0;
        req_valid   = 1'b0;
        rsp_ready   = 1'b0;
        req         = '0;
        rng         = 32'h77c6_71d5;
        mismatches  = 0;
        failures    = 0;
        cycle_limit = 0;
        // Unused entries keep an op code that no case uses
        foreach (cases_mem[i])
            cases_mem[i] = ~32'(i);
        $readmemh("sdram_cases.txt", cases_mem);
        n_cases = 0;
        while (n_cases < MAX_CASES && cases_mem[4*n_cases] <= 32'd2)
            n_cases++;
        cycle_limit = 2 + 4*INIT_GAP + (n_cases + 2*N_RAND) * 8 * 2;
        repeat (2) @(posedge CLK);
        RESET_n <= 1'b1;
        check_init_log();
        for (int i = 0; i < n_cases; i++)
        begin
            case (cases_mem[4*i][1:0])
                2'd0:    read_half(cases_mem[4*i+1][22:0], cases_mem[4*i+3][15:0]);
                2'd1:    write_byte(cases_mem[4*i+1][22:0], cases_mem[4*i+2][7:0]);
                default: refresh_once();
            endcase
        end
        for (int i = 0; i < N_RAND; i++)
        begin
            addr = 23'(next_rand());
            wd   = 8'(next_rand());
            write_byte(addr, wd);
            read_half(addr, {sb_byte(addr ^ 23'h1), sb_byte(addr)});
        end
        n_assert = i_dut.i_ctrl.i_props.n_fail;
        $display("Mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 mismatches, failures, n_assert);
        if (mismatches == 0 && failures == 0 && n_assert == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sdram_cases.txt ====
// op (0 read, 1 write, 2 refresh)  byte address  write byte  expected read
// All four lanes of one word, then reads in both byte orders
1 000100 11 0000
1 000101 22 0000
1 000102 33 0000
1 000103 44 0000
0 000100 00 2211
0 000101 00 1122
0 000102 00 4433
0 000103 00 3344
1 000102 a5 0000
0 000102 00 44a5
0 000100 00 2211
2 000000 00 0000
// Last bank, row and column
1 7ffffd 5c 0000
1 7ffffc c3 0000
0 7ffffc 00 5cc3
0 7ffffd 00 c35c
// Bank 1 row 5 column 3
1 20140c 9e 0000
1 20140d 07 0000
0 20140c 00 079e
2 000000 00 0000

// ==== vlog.f ====
sdram_pkg.sv
sdram_ctrl.sv
sdram_addr_map.sv
sdram_dq_path.sv
sdram_top.sv
sdram_model.sv
sdram_properties.sv
tb_sdram.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sdram
FILELIST  ?= vlog.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD LOG"

test:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
